/* lcd_driver.f */
source/lcd_pkg.sv
source/lcd_timing.sv
source/lcd_pixel_gen.sv
source/lcd_driver.sv
bench/tb_lcd_driver.sv

/* Bender.yml */
package:
  name: lcd_driver

sources:
  - files:
      - source/lcd_pkg.sv
      - source/lcd_timing.sv
      - source/lcd_pixel_gen.sv
      - source/lcd_driver.sv
  - target: test
    files:
      - bench/tb_lcd_driver.sv

/* bench/tb_lcd_driver.sv */
`default_nettype none

module tb_lcd_driver;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int FRAME_CYCLES = int'(lcd_pkg::H_TOTAL) * int'(lcd_pkg::V_TOTAL);
	localparam int WAIT_LIMIT   = 2 * FRAME_CYCLES + 100;   // two frames plus slack
	localparam int FRAME_PIXELS = int'(lcd_pkg::H_DISP) * int'(lcd_pkg::V_DISP);

	typedef struct packed {
		lcd_pkg::disp_mode_e drive;      // set before the frame starts
		lcd_pkg::disp_mode_e exp_mode;   // mode the frame must show
		logic                change;     // switch disp_mode halfway through
		lcd_pkg::disp_mode_e later;      // mode driven at that point
	} frame_entry_t;

	logic                         clk;
	logic                         rst_n;
	lcd_pkg::disp_mode_e          disp_mode;
	logic [lcd_pkg::PIXEL_W-1:0]  lcd_data;
	logic                         lcd_dclk;
	logic                         lcd_blank;
	logic                         lcd_hs;
	logic                         lcd_vs;
	logic                         lcd_en;
	logic [lcd_pkg::PIXEL_W-1:0]  lcd_rgb;
	logic                         lcd_request;
	logic                         lcd_framesync;
	logic [lcd_pkg::COORD_W-1:0]  lcd_xpos;
	logic [lcd_pkg::COORD_W-1:0]  lcd_ypos;

	logic [lcd_pkg::PIXEL_W-1:0]  exp_q [$];     // pixels owed to the panel
	logic [31:0]                  rnd_state = 32'd6865;
	logic                         mon_on = 1'b0;
	logic                         mon_prev_hs = 1'b0;   // pins sit low after reset
	logic                         mon_prev_vs = 1'b0;
	logic                         h_seen = 1'b0;
	logic                         v_seen = 1'b0;
	int                           h_cyc = 0;
	int                           h_low = 0;
	int                           lines = 0;
	int                           vs_lines = 0;
	int                           en_cyc = 0;

	// one entry per frame, last two cover the mid-frame switch
	frame_entry_t frames [0:4] = '{
		'{lcd_pkg::MODE_BAR,      lcd_pkg::MODE_BAR,      1'b0, lcd_pkg::MODE_BAR},
		'{lcd_pkg::MODE_GRID,     lcd_pkg::MODE_GRID,     1'b0, lcd_pkg::MODE_GRID},
		'{lcd_pkg::MODE_GRADIENT, lcd_pkg::MODE_GRADIENT, 1'b0, lcd_pkg::MODE_GRADIENT},
		'{lcd_pkg::MODE_EXTERNAL, lcd_pkg::MODE_EXTERNAL, 1'b1, lcd_pkg::MODE_GRID},
		'{lcd_pkg::MODE_GRID,     lcd_pkg::MODE_GRID,     1'b0, lcd_pkg::MODE_GRID}
	};

	lcd_driver u_dut (.*);

	always #20 clk = ~clk;   // 40 ns pixel clock

	// ------------------------------------------------------------
	// reference model and helpers
	// ------------------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] v;
		v = s ^ (s << 13);
		v = v ^ (v >> 17);
		return v ^ (v << 5);
	endfunction

	function automatic logic [lcd_pkg::PIXEL_W-1:0] ref_pixel
	(
		input lcd_pkg::disp_mode_e          mode,
		input logic [lcd_pkg::COORD_W-1:0]  x,
		input logic [lcd_pkg::COORD_W-1:0]  y
	);
		logic [15:0] ramp;
		ramp = 16'(x[5:1]);
		case (mode)
			lcd_pkg::MODE_BAR:      return lcd_pkg::BAR_COLORS[x / lcd_pkg::BAR_WIDTH];
			lcd_pkg::MODE_GRID:     return (x[lcd_pkg::GRID_BIT] == y[lcd_pkg::GRID_BIT]) ?
				16'hffff : 16'h0000;
			lcd_pkg::MODE_GRADIENT: return (ramp << 11) | (ramp << 6) | ramp;   // green = ramp*2
			default:                return 16'h0000;
		endcase
	endfunction

	task automatic fail_run;
		$display("FAIL: see errors above");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_pixel(input string name, input logic [lcd_pkg::PIXEL_W-1:0] got,
		input logic [lcd_pkg::PIXEL_W-1:0] exp);
		if (got !== exp)
		begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			fail_run();
		end
	endtask

	task automatic check_pos(input string name, input lcd_pkg::lcd_pos_t got,
		input lcd_pkg::lcd_pos_t exp);
		if (got !== exp)
		begin
			$display("[FAIL] %s got x=%h y=%h expected x=%h y=%h", name, got.x, got.y,
				exp.x, exp.y);
			fail_run();
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
		begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			fail_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			fail_run();
		end
	endtask

	// returns on the negedge where lcd_vs has just dropped
	task automatic wait_frame_start;
		logic prev;
		int   n;
		n = 0;
		@(negedge clk);
		prev = lcd_vs;
		@(negedge clk);
		while (!(prev && !lcd_vs))
		begin
			if (n == WAIT_LIMIT)
			begin
				$display("timed out waiting for lcd_vs to start a frame");
				fail_run();
			end
			n++;
			prev = lcd_vs;
			@(negedge clk);
		end
	endtask

	// ------------------------------------------------------------
	// one frame, user model and pixel checks
	// ------------------------------------------------------------
	task automatic verify_frame(input frame_entry_t f);
		lcd_pkg::lcd_pos_t            got_pos;
		lcd_pkg::lcd_pos_t            exp_pos;
		logic [lcd_pkg::PIXEL_W-1:0]  exp_pix;
		logic [lcd_pkg::PIXEL_W-1:0]  answer;
		logic [lcd_pkg::COORD_W-1:0]  x;
		logic [lcd_pkg::COORD_W-1:0]  y;
		logic                         answer_due;
		logic                         req_d1;
		logic                         req_d2;
		logic                         prev_req;
		logic                         prev_en;
		int                           run;
		int                           runs;
		int                           total;
		int                           n;
		exp_q.delete();
		{answer_due, req_d1, req_d2, prev_req, prev_en} = '0;
		x = '0;
		y = '0;
		answer = '0;
		run = 0;
		runs = 0;
		total = 0;
		n = 0;
		while (runs < int'(lcd_pkg::V_DISP))
		begin
			@(posedge clk);
			if (answer_due)
			begin
				lcd_data <= answer;   // user answers one cycle after the request
			end
			if (f.change && total == FRAME_PIXELS / 2)
			begin
				disp_mode <= f.later;   // must only take effect next frame
			end
			@(negedge clk);
			n++;
			if (n > WAIT_LIMIT)
			begin
				$display("frame did not finish its active lines in time");
				fail_run();
			end
			got_pos = {lcd_xpos, lcd_ypos};
			exp_pos = '0;                     // coordinates idle at zero
			answer_due = lcd_request;
			if (lcd_request)
			begin
				exp_pos.x = x;
				exp_pos.y = y;
				rnd_state = xorshift32(rnd_state);
				answer = rnd_state[15:0] ^ {x[7:0], y[7:0]};
				exp_q.push_back((f.exp_mode == lcd_pkg::MODE_EXTERNAL) ?
					answer : ref_pixel(f.exp_mode, x, y));
				x++;
			end
			else if (prev_req)
			begin
				x = '0;   // next line of requests
				y++;
			end
			check_pos("lcd_xpos/lcd_ypos", got_pos, exp_pos);
			prev_req = lcd_request;
			check_flag("lcd_en", lcd_en, req_d2);   // two cycles behind request
			req_d2 = req_d1;
			req_d1 = lcd_request;
			exp_pix = '0;
			if (lcd_en)
			begin
				exp_pix = exp_q.pop_front();
				total++;
				run++;
			end
			else if (prev_en)
			begin
				check_count("enable run length", run, int'(lcd_pkg::H_DISP));
				runs++;
				run = 0;
			end
			check_pixel("lcd_rgb", lcd_rgb, exp_pix);
			prev_en = lcd_en;
		end
	endtask

	// ------------------------------------------------------------
	// sync monitor
	// ------------------------------------------------------------
	always @(negedge clk)
	begin
		if (mon_on)
		begin
			check_flag("lcd_blank", lcd_blank, lcd_hs & lcd_vs);
			check_flag("lcd_framesync", lcd_framesync, lcd_vs);
			if (mon_prev_vs && !lcd_vs)
			begin
				if (v_seen)
				begin
					check_count("lines per frame", lines, int'(lcd_pkg::V_TOTAL));
					check_count("vs low lines", vs_lines, int'(lcd_pkg::V_SYNC));
					check_count("enable cycles per frame", en_cyc, FRAME_PIXELS);
				end
				v_seen = 1'b1;   // first full frame starts here
				lines = 0;
				vs_lines = 0;
				en_cyc = 0;
			end
			if (mon_prev_hs && !lcd_hs)
			begin
				if (h_seen)
				begin
					check_count("cycles per line", h_cyc, int'(lcd_pkg::H_TOTAL));
					check_count("hs low cycles", h_low, int'(lcd_pkg::H_SYNC));
				end
				h_seen = 1'b1;
				h_cyc = 0;
				h_low = 0;
				lines++;
				if (!lcd_vs)
				begin
					vs_lines++;
				end
			end
			h_cyc++;
			if (!lcd_hs)
			begin
				h_low++;
			end
			if (lcd_en)
			begin
				en_cyc++;   // whole frame, not just the checked lines
			end
			mon_prev_hs = lcd_hs;
			mon_prev_vs = lcd_vs;
		end
	end

	// panel clock sampled mid phase, away from both edges
	always @(clk)
	begin
		#10;
		if (mon_on)
		begin
			check_flag("lcd_dclk", lcd_dclk, !clk);
		end
	end

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		disp_mode = lcd_pkg::MODE_BAR;
		lcd_data = '0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_flag("lcd_en", lcd_en, 1'b0);
		check_flag("lcd_request", lcd_request, 1'b0);
		check_pixel("lcd_rgb", lcd_rgb, '0);
		mon_on = 1'b1;
		for (int i = 0; i < 5; i++)
		begin
			@(posedge clk);
			disp_mode <= frames[i].drive;   // latched at the coming frame start
			wait_frame_start();
			verify_frame(frames[i]);
		end
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

/* source/lcd_driver.sv */
`default_nettype none

module lcd_driver
(
	input  wire                          clk,             // pixel clock
	input  wire                          rst_n,           // sync reset, active low
	input  wire lcd_pkg::disp_mode_e     disp_mode,       // pattern select
	input  wire [lcd_pkg::PIXEL_W-1:0]   lcd_data,        // user pixel data
	// panel side
	output logic                         lcd_dclk,        // panel clock, inverted
	output logic                         lcd_blank,       // low in any sync
	output logic                         lcd_hs,          // active low
	output logic                         lcd_vs,          // active low
	output logic                         lcd_en,          // data enable
	output logic [lcd_pkg::PIXEL_W-1:0]  lcd_rgb,         // rgb565
	// user side
	output logic                         lcd_request,     // pixel wanted next cycle
	output logic                         lcd_framesync,   // vs, pin aligned
	output logic [lcd_pkg::COORD_W-1:0]  lcd_xpos,        // requested column
	output logic [lcd_pkg::COORD_W-1:0]  lcd_ypos         // requested row
);

	logic                         pixel_req;
	lcd_pkg::lcd_pos_t            pos;
	lcd_pkg::lcd_ctrl_t           ctrl;       // timing stage
	lcd_pkg::lcd_ctrl_t           ctrl_out;   // pin stage
	logic [lcd_pkg::PIXEL_W-1:0]  rgb;

	lcd_timing u_timing
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.pixel_req (pixel_req),
		.pos       (pos),
		.ctrl      (ctrl)
	);

	lcd_pixel_gen u_pixel
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.disp_mode (disp_mode),
		.pixel_req (pixel_req),
		.pos       (pos),
		.ctrl      (ctrl),
		.lcd_data  (lcd_data),
		.rgb       (rgb),
		.ctrl_out  (ctrl_out)
	);

	// ----------------------------------------------------------
	// pins
	// ----------------------------------------------------------
	assign lcd_dclk  = ~clk;   // panel samples mid-cycle
	assign lcd_hs    = ctrl_out.hs;
	assign lcd_vs    = ctrl_out.vs;
	assign lcd_en    = ctrl_out.de;
	assign lcd_blank = ctrl_out.hs & ctrl_out.vs;
	assign lcd_rgb   = rgb;

	assign lcd_request   = pixel_req;   // two cycles ahead of lcd_en data
	assign lcd_xpos      = pos.x;
	assign lcd_ypos      = pos.y;
	assign lcd_framesync = ctrl_out.vs;

endmodule

`default_nettype wire

/* source/lcd_pixel_gen.sv */
`default_nettype none

module lcd_pixel_gen
(
	input  wire                          clk,         // pixel clock
	input  wire                          rst_n,       // sync reset, active low
	input  wire lcd_pkg::disp_mode_e     disp_mode,   // sampled at frame start only
	input  wire                          pixel_req,   // position valid this cycle
	input  wire lcd_pkg::lcd_pos_t       pos,         // requested coordinates
	input  wire lcd_pkg::lcd_ctrl_t      ctrl,        // one cycle behind the counters
	input  wire [lcd_pkg::PIXEL_W-1:0]   lcd_data,    // user answer, one cycle after req
	output logic [lcd_pkg::PIXEL_W-1:0]  rgb,         // pixel to the panel
	output lcd_pkg::lcd_ctrl_t           ctrl_out     // ctrl aligned with rgb
);

	lcd_pkg::disp_mode_e          mode_q;   // mode of the current frame
	lcd_pkg::lcd_pos_t            pos_q;    // position of the pixel now being formed
	logic [lcd_pkg::PIXEL_W-1:0]  pix;      // selected pattern pixel
	logic [lcd_pkg::PIXEL_W-1:0]  bar_pix;
	logic [lcd_pkg::PIXEL_W-1:0]  grid_pix;
	logic [lcd_pkg::PIXEL_W-1:0]  grad_pix;

	// bar number from column, compare chain instead of a divide by 60
	function automatic logic [lcd_pkg::BAR_SEL_W-1:0] bar_index
	(
		input logic [lcd_pkg::COORD_W-1:0] x
	);
		logic [lcd_pkg::BAR_SEL_W-1:0] idx;
		idx = '0;
		for (int i = 1; i < lcd_pkg::BAR_COUNT; i++)
		begin
			if (x >= lcd_pkg::BAR_WIDTH * i)
			begin
				idx = idx + 1'b1;   // past another bar edge
			end
		end
		return idx;
	endfunction

	// ----------------------------------------------------------
	// mode latch
	// ----------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			mode_q <= lcd_pkg::MODE_BAR;
		end
		else if (ctrl.frame_start)
		begin
			mode_q <= disp_mode;   // whole frame in one mode
		end
	end

	// ----------------------------------------------------------
	// position stage
	// ----------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (pixel_req)
		begin
			pos_q <= pos;   // held for the compute cycle
		end
	end

	// ----------------------------------------------------------
	// patterns
	// ----------------------------------------------------------
	assign bar_pix = lcd_pkg::BAR_COLORS[bar_index(pos_q.x)];

	// white where both grid bits agree
	assign grid_pix = (pos_q.x[lcd_pkg::GRID_BIT] == pos_q.y[lcd_pkg::GRID_BIT]) ?
		lcd_pkg::COLOR_WHITE : lcd_pkg::COLOR_BLACK;

	// r = x[5:1], g = {x[5:1], 0}, b = x[5:1]
	assign grad_pix = {pos_q.x[5:1], pos_q.x[5:1], 1'b0, pos_q.x[5:1]};

	always_comb
	begin
		unique case (mode_q)
			lcd_pkg::MODE_BAR:      pix = bar_pix;
			lcd_pkg::MODE_GRID:     pix = grid_pix;
			lcd_pkg::MODE_GRADIENT: pix = grad_pix;
			lcd_pkg::MODE_EXTERNAL: pix = lcd_data;   // user answers in this cycle
			default:                pix = lcd_pkg::COLOR_BLACK;
		endcase
	end

	// ----------------------------------------------------------
	// output register, pixel and ctrl leave together
	// ----------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rgb      <= '0;
			ctrl_out <= '0;
		end
		else
		begin
			rgb      <= ctrl.de ? pix : lcd_pkg::COLOR_BLACK;   // black outside de
			ctrl_out <= ctrl;
		end
	end

endmodule

`default_nettype wire

/* source/lcd_timing.sv */
`default_nettype none

module lcd_timing
(
	input  wire                 clk,         // pixel clock
	input  wire                 rst_n,       // sync reset, active low
	output logic                pixel_req,   // one cycle ahead of de
	output lcd_pkg::lcd_pos_t   pos,         // coordinates for pixel_req, zero otherwise
	output lcd_pkg::lcd_ctrl_t  ctrl         // registered sync and enable
);

	logic [lcd_pkg::COORD_W-1:0] hcnt;   // pixel within line
	logic [lcd_pkg::COORD_W-1:0] vcnt;   // line within frame
	logic line_end;                      // last pixel of a line
	logic frame_end;                     // last line of a frame

	logic h_act;       // column inside active window
	logic h_req;       // column inside request window
	logic v_act;       // line inside active window
	logic req_win;     // request decode
	logic hs_win;      // hs level, low in sync
	logic vs_win;      // vs level, low in sync
	logic fs_win;      // origin of the frame

	// ----------------------------------------------------------
	// counters
	// ----------------------------------------------------------
	assign line_end  = (hcnt == lcd_pkg::H_LAST);
	assign frame_end = (vcnt == lcd_pkg::V_LAST);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			hcnt <= '0;
		end
		else if (line_end)
		begin
			hcnt <= '0;   // wrap at H_TOTAL
		end
		else
		begin
			hcnt <= hcnt + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			vcnt <= '0;
		end
		else if (line_end)
		begin
			if (frame_end)
			begin
				vcnt <= '0;   // wrap at V_TOTAL
			end
			else
			begin
				vcnt <= vcnt + 1'b1;
			end
		end
	end

	// ----------------------------------------------------------
	// window decode
	// ----------------------------------------------------------
	assign h_act = (hcnt >= lcd_pkg::H_ACT_START) && (hcnt < lcd_pkg::H_ACT_END);
	assign h_req = (hcnt >= lcd_pkg::H_REQ_START) && (hcnt < lcd_pkg::H_REQ_END);
	assign v_act = (vcnt >= lcd_pkg::V_ACT_START) && (vcnt < lcd_pkg::V_ACT_END);

	assign req_win = h_req && v_act;   // same lines as de, shifted one column early
	assign hs_win  = (hcnt >= lcd_pkg::H_SYNC);
	assign vs_win  = (vcnt >= lcd_pkg::V_SYNC);
	assign fs_win  = (hcnt == '0) && (vcnt == '0);

	// ----------------------------------------------------------
	// registered outputs, all one cycle behind the counters
	// ----------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			pixel_req <= 1'b0;
			pos       <= '0;
			ctrl      <= '0;   // hs and vs low, counters sit in sync
		end
		else
		begin
			pixel_req <= req_win;
			if (req_win)
			begin
				pos.x <= hcnt - lcd_pkg::H_REQ_START;   // 0 at first request
				pos.y <= vcnt - lcd_pkg::V_ACT_START;
			end
			else
			begin
				pos <= '0;   // idle coordinates read as zero
			end
			ctrl.hs          <= hs_win;
			ctrl.vs          <= vs_win;
			ctrl.de          <= h_act && v_act;   // lands one cycle after the request
			ctrl.frame_start <= fs_win;
		end
	end

endmodule

`default_nettype wire

/* source/lcd_pkg.sv */
`default_nettype none

package lcd_pkg;

	// ----------------------------------------------------------
	// widths
	// ----------------------------------------------------------
	localparam int COORD_W = 11;                   // counter and coordinate width
	localparam int PIXEL_W = 16;                   // rgb565

	// ----------------------------------------------------------
	// 480x272 panel timing, pixel clocks and lines
	// ----------------------------------------------------------
	localparam logic [COORD_W-1:0] H_SYNC  = 11'd41;   // hs low width
	localparam logic [COORD_W-1:0] H_BACK  = 11'd2;    // back porch
	localparam logic [COORD_W-1:0] H_DISP  = 11'd480;  // active pixels
	localparam logic [COORD_W-1:0] H_FRONT = 11'd2;    // front porch
	localparam logic [COORD_W-1:0] H_TOTAL = H_SYNC + H_BACK + H_DISP + H_FRONT;  // 525

	localparam logic [COORD_W-1:0] V_SYNC  = 11'd10;   // vs low lines
	localparam logic [COORD_W-1:0] V_BACK  = 11'd2;
	localparam logic [COORD_W-1:0] V_DISP  = 11'd272;  // active lines
	localparam logic [COORD_W-1:0] V_FRONT = 11'd2;
	localparam logic [COORD_W-1:0] V_TOTAL = V_SYNC + V_BACK + V_DISP + V_FRONT;  // 286

	// derived window edges
	localparam logic [COORD_W-1:0] H_LAST      = H_TOTAL - 11'd1;       // last hcnt of a line
	localparam logic [COORD_W-1:0] V_LAST      = V_TOTAL - 11'd1;       // last line of a frame
	localparam logic [COORD_W-1:0] H_ACT_START = H_SYNC + H_BACK;       // first de column
	localparam logic [COORD_W-1:0] H_ACT_END   = H_ACT_START + H_DISP;  // one past last
	localparam logic [COORD_W-1:0] H_REQ_START = H_ACT_START - 11'd1;   // request leads by one
	localparam logic [COORD_W-1:0] H_REQ_END   = H_ACT_END - 11'd1;
	localparam logic [COORD_W-1:0] V_ACT_START = V_SYNC + V_BACK;       // first active line
	localparam logic [COORD_W-1:0] V_ACT_END   = V_ACT_START + V_DISP;

	// ----------------------------------------------------------
	// test pattern constants
	// ----------------------------------------------------------
	localparam int BAR_COUNT = 8;
	localparam logic [COORD_W-1:0] BAR_WIDTH = H_DISP / 11'd8;   // 60 pixels per bar
	localparam int BAR_SEL_W = $clog2(BAR_COUNT);

	// left to right
	localparam logic [0:BAR_COUNT-1][PIXEL_W-1:0] BAR_COLORS = {
		16'hf800,   // red
		16'h07e0,   // green
		16'h001f,   // blue
		16'hf81f,   // magenta
		16'hffe0,   // yellow
		16'h07ff,   // cyan
		16'hffff,   // white
		16'hfc00    // orange
	};

	localparam int GRID_BIT = 5;                            // 32 pixel squares
	localparam logic [PIXEL_W-1:0] COLOR_WHITE = 16'hffff;
	localparam logic [PIXEL_W-1:0] COLOR_BLACK = 16'h0000;

	// ----------------------------------------------------------
	// types
	// ----------------------------------------------------------
	typedef enum logic [1:0] {
		MODE_BAR      = 2'd0,   // vertical colour bars
		MODE_GRID     = 2'd1,   // checker grid
		MODE_GRADIENT = 2'd2,   // horizontal grey-ish ramp
		MODE_EXTERNAL = 2'd3    // user pixel data
	} disp_mode_e;

	typedef struct packed {
		logic [COORD_W-1:0] x;   // column in active area
		logic [COORD_W-1:0] y;   // row in active area
	} lcd_pos_t;

	typedef struct packed {
		logic hs;            // active low
		logic vs;            // active low
		logic de;            // active high
		logic frame_start;   // first cycle of vsync
	} lcd_ctrl_t;

endpackage

`default_nettype wire
